// File: Makefile
# Verilator build and run of the video DMA write channel testbench

VERILATOR  ?= verilator
TOP        ?= tb_vdma_write
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= TB FAILED
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)

SOURCES := $(shell cat $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
hdl/vdma_pkg.sv
hdl/pixel_packer.sv
hdl/beat_fifo.sv
hdl/burst_planner.sv
hdl/axi_burst_writer.sv
hdl/vdma_write_top.sv
verif/vdma_write_checker.sv
verif/tb_vdma_write.sv

// File: hdl/axi_burst_writer.sv
/* AXI write master FSM; takes one planner request at a time, issues AW, streams
   the beats from the FIFO head on W and waits for B before the next one */
module axi_burst_writer #(
    parameter int BURST_BEATS = 8
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  vdma_pkg::burst_req_t req,
    output logic                 req_done,
    input  vdma_pkg::beat_t      fifo_head,
    output logic                 fifo_rd,
    output vdma_pkg::addr_t      awaddr,
    output logic [7:0]           awlen,
    output logic                 awvalid,
    input  logic                 awready,
    output vdma_pkg::beat_t      wdata,
    output logic                 wlast,
    output logic                 wvalid,
    input  logic                 wready,
    input  logic                 bvalid,
    output logic                 bready
);
    import vdma_pkg::*;

    // counts 0 .. BURST_BEATS-1
    localparam int CNT_W = $clog2(BURST_BEATS + 1);

    writer_state_t    state;
    logic [CNT_W-1:0] beat_cnt;

    // channel valids straight from the state
    assign awvalid = (state == ADDR);
    assign wvalid  = (state == DATA);
    assign bready  = (state == RESP);

    // last beat once the counter reaches awlen
    assign wlast = wvalid && (8'(beat_cnt) == awlen);

    // fifo head goes out unregistered, pop on each accepted beat
    assign wdata   = fifo_head;
    assign fifo_rd = wvalid && wready;

    // burst closed by the write response
    assign req_done = bready && bvalid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (awready) begin
                        state    <= DATA;
                        beat_cnt <= '0;
                    end
                end
                DATA: begin
                    if (wready) begin
                        if (wlast) begin
                            state <= RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                RESP: begin
                    // response code is not checked
                    if (bvalid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address phase payload, taken as the request is accepted
    always_ff @(posedge clock) begin
        if (state == IDLE && req_valid) begin
            awaddr <= req.addr;
            awlen  <= 8'(req.beats - 1'b1);
        end
    end

endmodule

// File: hdl/beat_fifo.sv
/* single clock first-word-fall-through FIFO of AXI beats; the head is always
   on rd_data and level gives the occupancy for the burst planner */
module beat_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                wr,
    input  vdma_pkg::beat_t     wr_data,
    input  logic                rd,
    output vdma_pkg::beat_t     rd_data,
    output vdma_pkg::beat_cnt_t level
);
    import vdma_pkg::*;

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    beat_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    // drop writes when full, ignore reads when empty
    assign do_wr = wr && (level != beat_cnt_t'(FIFO_DEPTH));
    assign do_rd = rd && (level != '0);

    // oldest entry falls through
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // read and write together leave the level as is
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // storage
    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// File: hdl/burst_planner.sv
/* follows frame and line progress, sizes each write burst against the FIFO
   level and computes its AXI address; one request is open at a time */
module burst_planner #(
    parameter int BURST_BEATS = 8,
    parameter int LINE_STRIDE = 4096
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 vsync,
    input  vdma_pkg::addr_t      baseaddr,
    input  vdma_pkg::hsize_t     hactive,
    input  vdma_pkg::beat_cnt_t  fifo_level,
    output logic                 req_valid,
    output vdma_pkg::burst_req_t req,
    input  logic                 req_done
);
    import vdma_pkg::*;

    // beats per line, latched at vsync
    beat_cnt_t line_beats;
    // beats of the current line not yet requested
    beat_cnt_t remaining;
    addr_t     line_addr;
    addr_t     next_addr;
    beat_cnt_t frame_beats;
    beat_cnt_t burst_beats;
    logic      line_end;
    logic      can_req;
    addr_t     next_line;
    addr_t     burst_bytes;

    // hactive / 2 rounded up
    assign frame_beats = beat_cnt_t'((32'(hactive) + PIX_PER_BEAT - 1) / PIX_PER_BEAT);

    // full burst or the line tail
    assign burst_beats = (remaining < beat_cnt_t'(BURST_BEATS)) ?
                         remaining : beat_cnt_t'(BURST_BEATS);

    // fifo must already hold the whole burst
    assign can_req = !req_valid && (remaining != '0) && (fifo_level >= burst_beats);

    // current burst closes the line
    assign line_end = (remaining == req.beats);
    assign next_line = line_addr + addr_t'(LINE_STRIDE);
    assign burst_bytes = addr_t'(req.beats) * addr_t'(BEAT_BYTES);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            line_beats <= '0;
            remaining  <= '0;
            line_addr  <= '0;
            next_addr  <= '0;
            req_valid  <= 1'b0;
        end else if (vsync) begin
            // frame restart from the new base and width
            line_beats <= frame_beats;
            remaining  <= frame_beats;
            line_addr  <= baseaddr;
            next_addr  <= baseaddr;
            req_valid  <= 1'b0;
        end else if (req_done) begin
            req_valid <= 1'b0;
            if (line_end) begin
                // next line one stride up
                line_addr <= next_line;
                next_addr <= next_line;
                remaining <= line_beats;
            end else begin
                next_addr <= next_addr + burst_bytes;
                remaining <= remaining - req.beats;
            end
        end else if (can_req) begin
            req_valid <= 1'b1;
        end
    end

    // request payload follows the planner until it is raised,
    // then holds until req_done
    always_ff @(posedge clock) begin
        if (!req_valid) begin
            req.addr  <= next_addr;
            req.beats <= burst_beats;
        end
    end

endmodule

// File: hdl/pixel_packer.sv
/* widens native video pixels to 32-bit lanes and packs two per 64-bit beat;
   an odd pixel left at the end of a line goes out with a zero upper lane */
module pixel_packer (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             vsync,
    input  logic             de,
    input  vdma_pkg::pixel_t pixel,
    output logic             beat_wr,
    output vdma_pkg::beat_t  beat
);
    import vdma_pkg::*;

    // low lane waiting for its partner
    logic [LANE_W-1:0] lane_lo;
    logic [LANE_W-1:0] lane_in;
    // low lane holds a valid pixel
    logic              pending;
    logic              pair_done;
    logic              flush;

    // zero-extend into the lane
    assign lane_in = LANE_W'(pixel);

    // second pixel of a pair
    assign pair_done = de && pending && !vsync;
    // de dropped with half a beat held
    assign flush = !de && pending && !vsync;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            beat_wr <= 1'b0;
        end else begin
            // strobe lags the completing pixel by one cycle
            beat_wr <= pair_done || flush;
            if (vsync) begin
                // new frame never inherits half a beat
                pending <= 1'b0;
            end else if (de) begin
                pending <= !pending;
            end else begin
                pending <= 1'b0;
            end
        end
    end

    // beat payload
    always_ff @(posedge clock) begin
        if (de && !pending) begin
            lane_lo <= lane_in;
        end
        if (pair_done) begin
            // first pixel low, second high
            beat <= {lane_in, lane_lo};
        end else if (flush) begin
            // odd line end, pad upper lane
            beat <= {{LANE_W{1'b0}}, lane_lo};
        end
    end

endmodule

// File: hdl/vdma_pkg.sv
/* shared widths, types and the burst request record of the video write DMA;
   imported by every RTL module and by the bound checker */
package vdma_pkg;

    // native video side
    localparam int PIX_W = 24;
    // a pixel is zero-extended into one lane
    localparam int LANE_W = 32;
    localparam int PIX_PER_BEAT = 2;

    // AXI data beat, two lanes wide
    localparam int AXI_DATA_W = LANE_W * PIX_PER_BEAT;
    localparam int BEAT_BYTES = AXI_DATA_W / 8;
    localparam int ADDR_W = 32;

    typedef logic [PIX_W-1:0] pixel_t;
    // first pixel of a pair sits in the low lane
    typedef logic [AXI_DATA_W-1:0] beat_t;
    // byte address on the AXI side
    typedef logic [ADDR_W-1:0] addr_t;
    // pixels per line
    typedef logic [15:0] hsize_t;
    // line lengths, fifo levels and burst lengths in beats
    typedef logic [15:0] beat_cnt_t;

    // one burst as handed from planner to writer
    typedef struct packed {
        addr_t     addr;
        // 1 .. BURST_BEATS
        beat_cnt_t beats;
    } burst_req_t;

    // writer FSM, one burst in flight
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } writer_state_t;

endpackage

// File: hdl/vdma_write_top.sv
/* write channel of the video DMA; the packer and FIFO form the data path, the
   planner the request path, and the AXI writer joins both */
module vdma_write_top #(
    parameter int BURST_BEATS = 8,
    parameter int LINE_STRIDE = 4096,
    parameter int FIFO_DEPTH  = 64
) (
    input  logic             clock,
    input  logic             arst_n,
    // native video
    input  logic             vsync,
    input  logic             de,
    input  vdma_pkg::pixel_t pixel,
    // frame setup, sampled at vsync
    input  vdma_pkg::addr_t  baseaddr,
    input  vdma_pkg::hsize_t hactive,
    // AXI write address
    output vdma_pkg::addr_t  awaddr,
    output logic [7:0]       awlen,
    output logic             awvalid,
    input  logic             awready,
    // AXI write data
    output vdma_pkg::beat_t  wdata,
    output logic             wlast,
    output logic             wvalid,
    input  logic             wready,
    // AXI write response
    input  logic             bvalid,
    output logic             bready
);
    import vdma_pkg::*;

    logic       beat_wr;
    beat_t      beat;
    beat_cnt_t  fifo_level;
    beat_t      fifo_head;
    logic       fifo_rd;
    logic       req_valid;
    burst_req_t req;
    logic       req_done;

    // data path
    pixel_packer u_pixel_packer (
        .clock   (clock),
        .arst_n  (arst_n),
        .vsync   (vsync),
        .de      (de),
        .pixel   (pixel),
        .beat_wr (beat_wr),
        .beat    (beat)
    );

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_beat_fifo (
        .clock   (clock),
        .arst_n  (arst_n),
        .wr      (beat_wr),
        .wr_data (beat),
        .rd      (fifo_rd),
        .rd_data (fifo_head),
        .level   (fifo_level)
    );

    // request path
    burst_planner #(
        .BURST_BEATS (BURST_BEATS),
        .LINE_STRIDE (LINE_STRIDE)
    ) u_burst_planner (
        .clock      (clock),
        .arst_n     (arst_n),
        .vsync      (vsync),
        .baseaddr   (baseaddr),
        .hactive    (hactive),
        .fifo_level (fifo_level),
        .req_valid  (req_valid),
        .req        (req),
        .req_done   (req_done)
    );

    // AXI master
    axi_burst_writer #(
        .BURST_BEATS (BURST_BEATS)
    ) u_axi_burst_writer (
        .clock     (clock),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_done  (req_done),
        .fifo_head (fifo_head),
        .fifo_rd   (fifo_rd),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

// File: verif/tb_vdma_write.sv
/* testbench for the video DMA write channel; plays frames from a table into the
   DUT, acts as AXI slave and checks AW and W against a reference model */
module tb_vdma_write;
    timeunit 1ns;
    timeprecision 100ps;
    import vdma_pkg::*;

    localparam int BURST_BEATS = 8;
    localparam int LINE_STRIDE = 4096;
    localparam int FIFO_DEPTH  = 64;
    localparam int NUM_ROWS    = 4;
    localparam logic [31:0] SEED = 32'ha346f75f;

    // one frame: setup, line timing, stall odds, expected bursts per frame
    typedef struct packed {
        addr_t base;
        int    hactive;
        int    lines;
        int    gap;
        int    stall_pct;
        int    bursts;
    } row_t;

    // expected address phase
    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } aw_t;

    // odd widths, tails shorter than a burst, rising stall odds
    row_t rows [NUM_ROWS] = '{
        '{32'h1000_0000, 32, 3, 60, 0, 6},
        '{32'h2000_0400, 37, 4, 80, 25, 12},
        '{32'h0000_8000, 5, 3, 40, 40, 3},
        '{32'h3000_0000, 48, 3, 120, 50, 9}
    };

    logic       clock = 1'b0;
    logic       arst_n;
    logic       vsync;
    logic       de;
    pixel_t     pixel;
    addr_t      baseaddr;
    hsize_t     hactive;
    addr_t      awaddr;
    logic [7:0] awlen;
    logic       awvalid;
    logic       awready = 1'b0;
    beat_t      wdata;
    logic       wlast;
    logic       wvalid;
    logic       wready = 1'b0;
    logic       bvalid = 1'b0;
    logic       bready;

    // reference queues
    beat_t      exp_beats [$];
    aw_t        exp_aw [$];
    int         err_data;
    int         err_aw;
    int         err_other;
    int         pix_seed;
    int         axi_seed;
    int         stall_pct;
    int         aw_total;
    // burst being written and its write response
    logic [7:0] cur_len;
    int         burst_cnt;
    logic       b_owed;
    int         b_delay;

    vdma_write_top #(
        .BURST_BEATS (BURST_BEATS),
        .LINE_STRIDE (LINE_STRIDE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_vdma_write_top (
        .clock    (clock),
        .arst_n   (arst_n),
        .vsync    (vsync),
        .de       (de),
        .pixel    (pixel),
        .baseaddr (baseaddr),
        .hactive  (hactive),
        .awaddr   (awaddr),
        .awlen    (awlen),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wlast    (wlast),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

    bind axi_burst_writer vdma_write_checker u_writer_checker (
        .clock   (clock),
        .arst_n  (arst_n),
        .state   (state),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    always #4 clock = ~clock;

    // one stall draw at the current odds
    function automatic bit stalled();
        int r;
        r = $random(axi_seed) & 32'h7fff_ffff;
        return (r % 100) < stall_pct;
    endfunction

    // run time bound from the table, in cycles
    function automatic int budget_cycles();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            sum += rows[i].lines * (rows[i].hactive + rows[i].gap) * 4;
        end
        return sum + 2000;
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    // expected bursts of a frame, line by line
    task automatic plan_frame(row_t r);
        addr_t line_start;
        addr_t a;
        aw_t   e;
        int    rem;
        int    n;
        line_start = r.base;
        for (int l = 0; l < r.lines; l++) begin
            a = line_start;
            // hactive / 2 rounded up
            rem = (r.hactive + 1) / 2;
            while (rem > 0) begin
                n = (rem < BURST_BEATS) ? rem : BURST_BEATS;
                e.addr = a;
                e.len = 8'(n - 1);
                exp_aw.push_back(e);
                a = a + addr_t'(n * BEAT_BYTES);
                rem = rem - n;
            end
            line_start = line_start + addr_t'(LINE_STRIDE);
        end
    endtask

    // one line of random pixels, expected beats queued as pairs complete
    task automatic drive_line(int npix);
        logic [31:0] lo_lane;
        pixel_t      px;
        lo_lane = '0;
        for (int p = 0; p < npix; p++) begin
            px = pixel_t'($random(pix_seed));
            de = 1'b1;
            pixel = px;
            if (p % 2 == 0) begin
                lo_lane = {8'h00, px};
            end else begin
                exp_beats.push_back({8'h00, px, lo_lane});
            end
            idle_cycles(1);
        end
        de = 1'b0;
        // odd pixel goes out with an empty upper lane
        if (npix % 2 == 1) begin
            exp_beats.push_back({32'h0, lo_lane});
        end
    endtask

    task automatic run_frame(row_t r);
        int aw_start;
        aw_start = aw_total;
        stall_pct = r.stall_pct;
        plan_frame(r);
        // setup sampled together with vsync
        baseaddr = r.base;
        hactive = hsize_t'(r.hactive);
        vsync = 1'b1;
        idle_cycles(1);
        vsync = 1'b0;
        idle_cycles(4);
        for (int l = 0; l < r.lines; l++) begin
            drive_line(r.hactive);
            idle_cycles(r.gap);
        end
        // drained and writer back in idle
        while (exp_aw.size() != 0 || exp_beats.size() != 0 || b_owed ||
               awvalid || wvalid || bready) begin
            idle_cycles(1);
        end
        idle_cycles(2);
        assert (aw_total - aw_start == r.bursts) else begin
            err_aw++;
            $display("FAIL aw burst count: got %h expected %h", aw_total - aw_start, r.bursts);
        end
    endtask

    task automatic check_aw();
        aw_t e;
        aw_total++;
        cur_len = awlen;
        burst_cnt = 0;
        assert (exp_aw.size() != 0) else begin
            err_aw++;
            $display("AW burst issued after the frame's last expected burst");
        end
        if (exp_aw.size() != 0) begin
            e = exp_aw.pop_front();
            assert (awaddr == e.addr) else begin
                err_aw++;
                $display("FAIL awaddr: got %h expected %h", awaddr, e.addr);
            end
            assert (awlen == e.len) else begin
                err_aw++;
                $display("FAIL awlen: got %h expected %h", awlen, e.len);
            end
        end
    endtask

    task automatic check_w();
        beat_t e;
        logic  last_exp;
        burst_cnt++;
        last_exp = (burst_cnt == int'(cur_len) + 1);
        assert (wlast == last_exp) else begin
            err_other++;
            $display("FAIL wlast: got %h expected %h", wlast, last_exp);
        end
        if (wlast) begin
            // response a few cycles later
            b_owed = 1'b1;
            b_delay = 1 + (($random(axi_seed) & 32'h7fff_ffff) % 3);
        end
        assert (exp_beats.size() != 0) else begin
            err_data++;
            $display("W beat written with no pixel data left to expect");
        end
        if (exp_beats.size() != 0) begin
            e = exp_beats.pop_front();
            assert (wdata == e) else begin
                err_data++;
                $display("FAIL wdata: got %h expected %h", wdata, e);
            end
        end
    endtask

    // handshakes sampled mid cycle where all signals are settled
    always @(negedge clock) begin
        if (arst_n) begin
            if (awvalid && awready) begin
                check_aw();
            end
            if (wvalid && wready) begin
                check_w();
            end
            if (bvalid && bready) begin
                b_owed = 1'b0;
            end
        end
    end

    // AXI slave outputs
    always @(posedge clock) begin
        #1;
        awready = !stalled();
        wready = !stalled();
        if (!b_owed) begin
            bvalid = 1'b0;
        end else if (b_delay == 0) begin
            bvalid = 1'b1;
        end else begin
            b_delay--;
        end
    end

    initial begin
        repeat (budget_cycles()) @(posedge clock);
        $display("timeout after %0d cycles, frames never drained", budget_cycles());
        $display("TB FAILED");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        vsync = 1'b0;
        de = 1'b0;
        pixel = '0;
        baseaddr = '0;
        hactive = '0;
        err_data = 0;
        err_aw = 0;
        err_other = 0;
        aw_total = 0;
        stall_pct = 0;
        b_owed = 1'b0;
        b_delay = 0;
        cur_len = '0;
        burst_cnt = 0;
        pix_seed = SEED;
        axi_seed = ~SEED;
        repeat (4) @(posedge clock);
        #1;
        arst_n = 1'b1;
        idle_cycles(2);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_frame(rows[i]);
        end
        $display("errors: data %0d aw %0d other %0d", err_data, err_aw, err_other);
        if (err_data + err_aw + err_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verif/vdma_write_checker.sv
/* AXI write channel assertions for the burst writer FSM;
   the testbench binds it into axi_burst_writer */
module vdma_write_checker (
    input logic                    clock,
    input logic                    arst_n,
    input vdma_pkg::writer_state_t state,
    input vdma_pkg::addr_t         awaddr,
    input logic [7:0]              awlen,
    input logic                    awvalid,
    input logic                    awready,
    input vdma_pkg::beat_t         wdata,
    input logic                    wlast,
    input logic                    wvalid,
    input logic                    wready,
    input logic                    bvalid,
    input logic                    bready
);
    timeunit 1ns;
    timeprecision 100ps;
    import vdma_pkg::*;

    // burst open from AW acceptance until its write response
    logic burst_open;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            burst_open <= 1'b0;
        end else if (awvalid && awready) begin
            burst_open <= 1'b1;
        end else if (bvalid && bready) begin
            burst_open <= 1'b0;
        end
    end

    // AW held with its payload until accepted
    aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
        else $error("AW valid or payload changed before awready");

    // W beat held until accepted
    w_hold: assert property (@(posedge clock) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("W valid or payload changed before wready");

    // one burst in flight, no new address before the response
    aw_single: assert property (@(posedge clock) disable iff (!arst_n)
        burst_open |-> !awvalid)
        else $error("new AW request while a burst is still open");

    // FSM idle and all channels quiet coming out of reset
    reset_quiet: assert property (@(posedge clock)
        $rose(arst_n) |-> state == IDLE && !awvalid && !wvalid && !bready)
        else $error("writer not idle or AXI valid/ready active right after reset");

endmodule
